// ==== include/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Data and instruction word width
`define XLEN 32

// Register file address width, 32 entries
`define REG_ADDR_W 5

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

// ==== rtl/core_pkg.sv ====
`include "core_config.svh"

package core_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [1:0] {
        IMM_NONE,
        IMM_I,
        IMM_U
    } imm_kind_e;

    // Execute unit commands
    typedef enum logic [1:0] {
        CMD_NOP,
        CMD_ADD,
        CMD_PASS,
        CMD_HALT
    } exu_cmd_e;

    // Operand A source
    typedef enum logic [1:0] {
        OPA_ZERO,
        OPA_REG,
        OPA_PC
    } opa_sel_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Decode to execute, 74 bits
    typedef struct packed {
        exu_cmd_e               cmd;
        opa_sel_e               opa_sel;
        logic [`XLEN-1:0]       opa_pc;
        logic [`XLEN-1:0]       opb;
        logic                   wen;
        logic [`REG_ADDR_W-1:0] rd;
    } decode_t;

    // One retired instruction, 71 bits
    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic                   wen;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } retire_t;

endpackage

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/10ps
`include "core_config.svh"

module fetch_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             halt_req,
    output logic [`XLEN-1:0] imem_addr,
    output logic             ex_valid,
    output logic [`XLEN-1:0] ex_pc,
    output logic             halted
);

    logic [`XLEN-1:0] pc;
    logic             run;

    // Ebreak in execute stops the pc at the same edge that sets the latch
    assign run       = !halted && !halt_req;
    assign imem_addr = pc;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= `RESET_PC;
            ex_valid <= 1'b0;
            halted   <= 1'b0;
        end else begin
            halted   <= halted | halt_req;
            ex_valid <= run;
            if (run) begin
                pc <= pc + `XLEN'(4);
            end
        end
    end

    // Execute-stage pc follows the word the memory returns next cycle
    always_ff @(posedge clk) begin
        if (run) begin
            ex_pc <= pc;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_pc_frozen: assert property (
        @(posedge clk) disable iff (rst)
        halted |=> $stable(pc)
    );

    a_no_issue_halted: assert property (
        @(posedge clk) disable iff (rst)
        halted |-> !ex_valid
    );

endmodule

// ==== rtl/decode_unit.sv ====
`timescale 1ns/10ps
`include "core_config.svh"

module decode_unit (
    input  logic [`XLEN-1:0]       inst,
    input  logic [`XLEN-1:0]       ex_pc,
    output logic [`REG_ADDR_W-1:0] rs1_addr,
    output core_pkg::decode_t      dec
);

    import core_pkg::*;

    opcode_e                opcode;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   is_ebreak;
    imm_kind_e              imm_kind;
    logic [`XLEN-1:0]       imm;
    exu_cmd_e               cmd;
    opa_sel_e               opa_sel;
    logic                   wen;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];

    // Full ebreak encoding, other SYSTEM words are no-ops
    assign is_ebreak = (opcode == SYSTEM) && (inst[31:20] == 12'd1)
                       && (inst[19:7] == '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Classification
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        cmd      = CMD_NOP;
        imm_kind = IMM_NONE;
        opa_sel  = OPA_ZERO;
        wen      = 1'b0;
        case (opcode)
            OP_IMM: begin
                // Only addi is supported
                if (funct3 == 3'b000) begin
                    cmd      = CMD_ADD;
                    imm_kind = IMM_I;
                    opa_sel  = OPA_REG;
                    wen      = 1'b1;
                end
            end
            LUI: begin
                cmd      = CMD_PASS;
                imm_kind = IMM_U;
                opa_sel  = OPA_ZERO;
                wen      = 1'b1;
            end
            AUIPC: begin
                cmd      = CMD_ADD;
                imm_kind = IMM_U;
                opa_sel  = OPA_PC;
                wen      = 1'b1;
            end
            SYSTEM: begin
                if (is_ebreak) begin
                    cmd = CMD_HALT;
                end
            end
            default: begin
                cmd = CMD_NOP;
            end
        endcase
    end

    // Immediate build
    always_comb begin
        case (imm_kind)
            IMM_I:   imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
            IMM_U:   imm = {inst[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign rs1_addr = (opa_sel == OPA_REG) ? inst[19:15] : '0;

    // x0 destination retires without a write
    assign dec.cmd     = cmd;
    assign dec.opa_sel = opa_sel;
    assign dec.opa_pc  = ex_pc;
    assign dec.opb     = imm;
    assign dec.wen     = wen && (rd != '0);
    assign dec.rd      = wen ? rd : '0;

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/10ps
`include "core_config.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    output logic [`XLEN-1:0]       rs1_data,
    input  logic                   wen,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic [`XLEN-1:0]       wdata
);

    localparam int NUM_REGS = 1 << `REG_ADDR_W;

    logic [`XLEN-1:0] regs [NUM_REGS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    // Async read, same-cycle write is seen at the next edge
    assign rs1_data = regs[rs1_addr];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_x0_zero: assert property (
        @(posedge clk) disable iff (rst)
        (rs1_addr == '0) |-> (rs1_data == '0)
    );

endmodule

// ==== rtl/execute_unit.sv ====
`timescale 1ns/10ps
`include "core_config.svh"

module execute_unit (
    input  logic                   ex_valid,
    input  logic [`XLEN-1:0]       ex_pc,
    input  core_pkg::decode_t      dec,
    input  logic [`XLEN-1:0]       rs1_data,
    output logic                   reg_wen,
    output logic [`REG_ADDR_W-1:0] reg_rd,
    output logic [`XLEN-1:0]       reg_wdata,
    output core_pkg::retire_t      retire,
    output logic                   halt_req
);

    import core_pkg::*;

    logic [`XLEN-1:0] opa;
    logic [`XLEN-1:0] result;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (dec.opa_sel)
            OPA_REG: opa = rs1_data;
            OPA_PC:  opa = dec.opa_pc;
            default: opa = '0;
        endcase
    end

    always_comb begin
        case (dec.cmd)
            CMD_ADD:  result = opa + dec.opb;
            CMD_PASS: result = dec.opb;
            default:  result = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write, retire and halt
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign reg_wen   = ex_valid && dec.wen;
    assign reg_rd    = dec.rd;
    assign reg_wdata = result;

    assign retire.valid = ex_valid;
    assign retire.pc    = ex_pc;
    assign retire.wen   = reg_wen;
    assign retire.rd    = dec.rd;
    assign retire.data  = result;

    // Held only while the ebreak sits in execute
    assign halt_req = ex_valid && (dec.cmd == CMD_HALT);

    // Decode must never mark ebreak as a write
    always_comb begin
        a_halt_no_write: assert final (!(halt_req && reg_wen));
    end

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/10ps
`include "core_config.svh"

module rv_core (
    input  logic              clk,
    input  logic              rst,
    output logic [`XLEN-1:0]  imem_addr,
    input  logic [`XLEN-1:0]  imem_data,
    output core_pkg::retire_t retire,
    output logic              halted
);

    import core_pkg::*;

    // Execute stage
    logic                   ex_valid;
    logic [`XLEN-1:0]       ex_pc;
    decode_t                dec;
    logic                   halt_req;

    // Register file ports
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic                   reg_wen;
    logic [`REG_ADDR_W-1:0] reg_rd;
    logic [`XLEN-1:0]       reg_wdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fetch
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    fetch_unit u_fetch (
        .clk       (clk),
        .rst       (rst),
        .halt_req  (halt_req),
        .imem_addr (imem_addr),
        .ex_valid  (ex_valid),
        .ex_pc     (ex_pc),
        .halted    (halted)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Execute stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Fetched word arrives aligned with ex_pc
    decode_unit u_decode (
        .inst     (imem_data),
        .ex_pc    (ex_pc),
        .rs1_addr (rs1_addr),
        .dec      (dec)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs1_data (rs1_data),
        .wen      (reg_wen),
        .rd       (reg_rd),
        .wdata    (reg_wdata)
    );

    execute_unit u_execute (
        .ex_valid  (ex_valid),
        .ex_pc     (ex_pc),
        .dec       (dec),
        .rs1_data  (rs1_data),
        .reg_wen   (reg_wen),
        .reg_rd    (reg_rd),
        .reg_wdata (reg_wdata),
        .retire    (retire),
        .halt_req  (halt_req)
    );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held over three rising edges
    initial begin
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== test/tb_rv_core.sv ====
`timescale 1ns/10ps
`include "core_config.svh"

module tb_rv_core;

    import core_pkg::*;

    localparam int PROG_WORDS        = 200;
    localparam int HALT_CHECK_CYCLES = 5;
    localparam int TIMEOUT_CYCLES    = PROG_WORDS + 30;

    logic             clk;
    logic             rst;
    logic [`XLEN-1:0] imem_addr;
    logic [`XLEN-1:0] imem_data;
    retire_t          retire;
    logic             halted;

    logic [`XLEN-1:0] mem [PROG_WORDS];
    integer           seed = 15216;
    int               cycle_count;

    // Reference state
    logic [`XLEN-1:0] model_regs [32];
    logic [`XLEN-1:0] model_pc;
    logic             model_halted;

    tb_clock clk_gen (
        .clk (clk),
        .rst (rst)
    );

    rv_core dut0 (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .retire    (retire),
        .halted    (halted)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Program and instruction memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    task automatic gen_program();
        int unsigned kind;
        int unsigned r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  prev_rd;
        logic [31:0] w;
        prev_rd = '0;
        for (int i = 0; i < PROG_WORDS - 1; i++) begin
            kind = $unsigned($random(seed)) % 8;
            rd   = 5'($unsigned($random(seed)) % 8);
            rs1  = 5'($unsigned($random(seed)) % 8);
            r    = $unsigned($random(seed));
            case (kind)
                0, 1, 2: w = enc_i(r[11:0], rs1, 3'b000, rd);
                // Reads the register written just before
                3:       w = enc_i(r[11:0], prev_rd, 3'b000, rd);
                4:       w = enc_u(r[19:0], rd, 7'b0110111);
                5:       w = enc_u(r[19:0], rd, 7'b0010111);
                6:       w = enc_i(r[11:0], rs1, 3'(1 + r % 7), rd);
                default: begin
                    w = r;
                    if (w[6:0] == 7'b0010011 || w[6:0] == 7'b0110111 ||
                        w[6:0] == 7'b0010111 || w[6:0] == 7'b1110011) begin
                        w[6:0] = 7'b0000011;
                    end
                end
            endcase
            mem[i]  = w;
            prev_rd = rd;
        end
        mem[PROG_WORDS - 1] = 32'h0010_0073;
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [29:0] idx;
        idx = addr[31:2];
        if (idx < 30'(PROG_WORDS)) begin
            return mem[idx[7:0]];
        end
        // Past the program end the word is its own address
        return addr;
    endfunction

    // Synchronous memory returns the word one cycle after its address
    initial begin
        imem_data <= '0;
        forever begin
            @(posedge clk);
            imem_data <= fetch_word(imem_addr);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic retire_t model_step(input logic [31:0] inst);
        retire_t     exp;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        rd    = inst[11:7];
        rs1   = inst[19:15];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_u = {inst[31:12], 12'b0};
        exp       = '0;
        exp.valid = 1'b1;
        exp.pc    = model_pc;
        case (inst[6:0])
            7'b0010011: begin
                if (inst[14:12] == 3'b000) begin
                    exp.rd   = rd;
                    exp.data = model_regs[rs1] + imm_i;
                end
            end
            7'b0110111: begin
                exp.rd   = rd;
                exp.data = imm_u;
            end
            7'b0010111: begin
                exp.rd   = rd;
                exp.data = model_pc + imm_u;
            end
            default: begin
                if (inst == 32'h0010_0073) begin
                    model_halted = 1'b1;
                end
            end
        endcase
        // No write lands in x0
        exp.wen = (exp.rd != 5'd0);
        if (exp.wen) begin
            model_regs[exp.rd] = exp.data;
        end
        model_pc = model_pc + 32'd4;
        return exp;
    endfunction

    task automatic report_mismatch(input retire_t exp, input retire_t got);
        $display("** Error at %0t: retire mismatch at pc %h", $time, exp.pc);
        $display("   expected v=%b wen=%b rd=%0d data=%h", exp.valid, exp.wen, exp.rd, exp.data);
        $display("   got      v=%b wen=%b rd=%0d data=%h pc=%h",
                 got.valid, got.wen, got.rd, got.data, got.pc);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic abort_run(input string msg);
        $display("%s at time %0t", msg, $time);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Comparison
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        retire_t          exp;
        logic             done;
        logic [`XLEN-1:0] frozen_addr;
        gen_program();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_pc     = `RESET_PC;
        model_halted = 1'b0;
        done         = 1'b0;

        @(negedge clk);
        while (rst) @(negedge clk);
        assert (imem_addr == `RESET_PC && !retire.valid && !halted)
            else abort_run("Core is not in its reset state after reset");

        while (!done) begin
            @(negedge clk);
            if (model_halted) begin
                assert (halted && !retire.valid)
                    else abort_run("Core did not halt after ebreak");
                done = 1'b1;
            end else begin
                assert (!halted) else abort_run("halted rose before ebreak retired");
                // One instruction retires every cycle
                exp = model_step(fetch_word(model_pc));
                assert (retire == exp) else report_mismatch(exp, retire);
            end
        end

        // Fetch address stays one word past the ebreak
        frozen_addr = imem_addr;
        assert (frozen_addr == model_pc)
            else abort_run("Fetch address is not frozen after the ebreak");
        repeat (HALT_CHECK_CYCLES) begin
            @(negedge clk);
            assert (halted && !retire.valid && imem_addr == frozen_addr)
                else abort_run("Core did not stay halted");
        end
        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: core did not halt within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped");
    end

endmodule

// ==== flist.f ====
+incdir+include
rtl/core_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/rv_core.sv
test/tb_clock.sv
test/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the rv_core testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_tb_rv_core
LOG=sim.log

verilator --binary --timing --assert \
    -f flist.f \
    --top-module tb_rv_core \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Build failed with status $build_status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation finished without failure"
exit 0
